//--- Makefile
VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "Simulation PASSED" $(LOG); then echo "no verdict in $(LOG)"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/lsu_patterns.txt
// columns, all hex: op size signed addr wdata expect
// op 0 load, 1 store, 2 store with a second strobe while busy; size 0 byte, 1 half, 2 word
1 2 0 0100 8765abcd 00000000
0 2 0 0100 00000000 8765abcd
0 1 1 0100 00000000 ffff8765
0 1 0 0100 00000000 00008765
0 1 0 0102 00000000 0000abcd
0 1 1 0103 00000000 ffffabcd
1 1 0 0104 00001234 00000000
0 1 1 0104 00000000 00001234
0 0 1 0100 00000000 ffffff87
0 0 0 0100 00000000 00000087
0 0 1 0101 00000000 00000065
0 0 0 0103 00000000 000000cd
0 0 1 0103 00000000 ffffffcd
0 0 1 0102 00000000 ffffffab
0 0 1 0104 00000000 00000012
1 0 0 0104 000000f0 00000000
0 1 0 0104 00000000 0000f034
1 0 0 0105 ffffff5a 00000000
0 1 0 0104 00000000 0000f05a
1 2 0 fffe 13579bdf 00000000
0 1 0 0000 00000000 00009bdf
0 2 0 fffe 00000000 13579bdf
2 1 0 0200 00004c3e 00000000
0 1 0 0200 00000000 00004c3e
2 2 0 0300 2468ace0 00000000
0 2 0 0300 00000000 2468ace0
2 0 0 0301 00000077 00000000
0 2 0 0300 00000000 2477ace0
0 0 0 0201 00000000 0000003e

//--- dv/lsu_tb.sv
// testbench for the load/store unit
// pattern file driven requests, value and timing checks, timeout

`timescale 1ns/1ps

module lsu_tb;

  logic              clk;
  logic              reset;
  lsu_pkg::lsu_req_t req;
  lsu_pkg::word_t    rdata;
  logic              output_valid;
  logic              write_done;
  logic              busy;

  logic [1:0]     pat_op[$];
  logic [1:0]     pat_size[$];
  logic           pat_sgn[$];
  lsu_pkg::addr_t pat_addr[$];
  lsu_pkg::word_t pat_wdata[$];
  lsu_pkg::word_t pat_exp[$];

  int value_errors = 0;
  int timing_errors = 0;
  int cycles = 0;
  int max_cycles = 1000;  // replaced once the pattern count is known

  lsu_top dut0 (
    .clk          (clk),
    .reset        (reset),
    .req          (req),
    .rdata        (rdata),
    .output_valid (output_valid),
    .write_done   (write_done),
    .busy         (busy)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout after %0d cycles, requests stopped completing", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;  // drive point
  endtask

  task automatic read_patterns(output bit ok);
    int          fd;
    int          n;
    string       line;
    logic [31:0] f [6];
    ok = 1'b0;
    fd = $fopen("dv/lsu_patterns.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        n = 0;
        if (line.len() > 1 && line.substr(0, 1) != "//") begin
          n = $sscanf(line, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
        end
        if (n == 6) begin
          pat_op.push_back(f[0][1:0]);
          pat_size.push_back(f[1][1:0]);
          pat_sgn.push_back(f[2][0]);
          pat_addr.push_back(f[3][15:0]);
          pat_wdata.push_back(f[4]);
          pat_exp.push_back(f[5]);
        end
      end
      $fclose(fd);
      ok = (pat_op.size() > 0);
    end
  endtask

  function automatic string access_name(input bit is_load, input logic [1:0] size);
    string sz;
    sz = (size == 2'd0) ? "b" : (size == 2'd1) ? "h" : "w";
    return is_load ? {"ld_", sz} : {"st_", sz};
  endfunction

  // cycles from the accept edge to the completion pulse
  function automatic int expected_latency(input bit is_load, input logic [1:0] size);
    if (is_load) begin
      return (size == 2'd2) ? 2 : 1;
    end
    return (size == 2'd1) ? 1 : 2;  // byte store reads first
  endfunction

  task automatic check_quiet(input string when);
    assert (!busy && !output_valid && !write_done) else begin
      timing_errors++;
      $display("outputs not low %s: busy=%b output_valid=%b write_done=%b",
               when, busy, output_valid, write_done);
    end
  endtask

  task automatic set_request(input int idx, input bit flip);
    req           = '0;
    req.load      = (pat_op[idx] == 2'd0);
    req.store     = (pat_op[idx] != 2'd0);
    req.size      = lsu_pkg::size_e'(pat_size[idx]);
    req.is_signed = pat_sgn[idx];
    req.addr      = pat_addr[idx];
    req.wdata     = flip ? ~pat_wdata[idx] : pat_wdata[idx];  // flipped for the ignored store
  endtask

  task automatic run_pattern(input int idx);
    string          name;
    bit             is_load;
    bit             seen;
    int             k;
    int             lat_exp;
    lsu_pkg::word_t got;
    is_load = (pat_op[idx] == 2'd0);
    name    = $sformatf("%s line %0d", access_name(is_load, pat_size[idx]), idx + 1);
    lat_exp = expected_latency(is_load, pat_size[idx]);
    while (busy) begin
      next_cycle();
    end
    repeat ($urandom % 4) next_cycle();
    set_request(idx, 1'b0);
    next_cycle();  // accept edge behind us
    if (pat_op[idx] == 2'd2) begin
      set_request(idx, 1'b1);  // must be ignored
    end else begin
      req = '0;
    end
    k    = 0;
    seen = 1'b0;
    got  = '0;
    while (!seen && k < 4) begin
      k++;
      #1;
      assert (busy) else begin
        timing_errors++;
        $display("busy low in cycle %0d of %s", k, name);
      end
      seen = is_load ? output_valid : write_done;
      got  = rdata;
      next_cycle();
      req = '0;
    end
    assert (seen) else begin
      timing_errors++;
      $display("no completion pulse within 4 cycles for %s", name);
    end
    if (seen) begin
      assert (k == lat_exp) else begin
        timing_errors++;
        $display("FAIL %s latency: expected %0d, got %0d", name, lat_exp, k);
      end
      if (is_load) begin
        assert (got == pat_exp[idx]) else begin
          value_errors++;
          $display("FAIL %s: expected %h, got %h", name, pat_exp[idx], got);
        end
      end
    end
    assert (!output_valid && !write_done) else begin
      timing_errors++;
      $display("completion pulse of %s lasted more than one cycle", name);
    end
    assert (!busy) else begin
      timing_errors++;
      $display("busy still high after %s completed", name);
    end
  endtask

  initial begin
    bit ok;
    void'($urandom(96));
    reset = 1'b0;
    req   = '0;
    read_patterns(ok);
    if (!ok) begin
      $display("could not read any patterns from dv/lsu_patterns.txt");
      $display("Simulation FAILED");
      $finish;
    end else begin
      max_cycles = 4 * pat_op.size() + 50;
      repeat (4) begin
        next_cycle();
        check_quiet("during reset");
      end
      reset = 1'b1;
      next_cycle();
      check_quiet("after reset");
      for (int i = 0; i < pat_op.size(); i++) begin
        run_pattern(i);
      end
      $display("errors: %0d value, %0d timing, %0d total over %0d patterns",
               value_errors, timing_errors, value_errors + timing_errors, pat_op.size());
      if (value_errors + timing_errors == 0) begin
        $display("Simulation PASSED");
      end else begin
        $display("Simulation FAILED");
      end
      $finish;
    end
  end

endmodule

//--- rtl/halfword_ram.sv
// halfword data memory
// combinational read, write on the clock edge

`timescale 1ns/1ps

module halfword_ram #(
  parameter int ADDR_W = 16
) (
  input  logic              clk,
  input  logic [ADDR_W-2:0] addr,
  input  logic              we,
  input  lsu_pkg::half_t    wdata,
  output lsu_pkg::half_t    rdata
);

  localparam int DEPTH = 2 ** (ADDR_W - 1);  // one entry per halfword index

  lsu_pkg::half_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  assign rdata = mem[addr];

endmodule

//--- rtl/lsu_datapath.sv
// execute stage address and write-data path
// halfword address select, old halfword capture, store byte merge

`timescale 1ns/1ps

module lsu_datapath #(
  parameter int ADDR_W = 16
) (
  input  logic               clk,
  input  logic               reset,
  input  lsu_pkg::lsu_ctrl_t ctrl,
  input  lsu_pkg::lsu_hold_t hold,
  input  lsu_pkg::half_t     ram_rdata,
  output logic [ADDR_W-2:0]  ram_addr,
  output logic               ram_we,
  output lsu_pkg::half_t     ram_wdata
);

  logic [ADDR_W-2:0] base_addr;
  logic [ADDR_W-2:0] next_addr;
  lsu_pkg::half_t    old_q;
  logic [7:0]        new_byte;

  assign base_addr = hold.half_addr[ADDR_W-2:0];
  assign next_addr = base_addr + {{(ADDR_W-2){1'b0}}, 1'b1};  // wraps at the top

  assign ram_addr = ctrl.addr_next ? next_addr : base_addr;
  assign ram_we   = ctrl.mem_we;

  // old halfword for a byte store
  always_ff @(posedge clk) begin
    if (!reset) begin
      old_q <= '0;
    end else if (ctrl.capture_old) begin
      old_q <= ram_rdata;
    end
  end

  assign new_byte = hold.wdata[7:0];

  always_comb begin
    case (ctrl.wsel)
      lsu_pkg::WSEL_HIGH: begin
        ram_wdata = hold.wdata[31:16];
      end
      lsu_pkg::WSEL_MERGE: begin
        // byte_lo picks bits 7:0 in big-endian order
        if (hold.byte_lo) begin
          ram_wdata = {old_q[15:8], new_byte};
        end else begin
          ram_wdata = {new_byte, old_q[7:0]};
        end
      end
      default: begin
        ram_wdata = hold.wdata[15:0];  // WSEL_LOW
      end
    endcase
  end

endmodule

//--- rtl/lsu_decode.sv
// decode stage of the load/store unit
// request classification and request hold register

`timescale 1ns/1ps

module lsu_decode #(
  parameter int ADDR_W = 16
) (
  input  logic                clk,
  input  logic                reset,
  input  lsu_pkg::lsu_req_t   req,
  input  logic                idle,
  output lsu_pkg::op_e        cmd,
  output lsu_pkg::lsu_hold_t  hold
);

  lsu_pkg::lsu_hold_t hold_q;

  // load has priority over store while idle
  always_comb begin
    cmd = lsu_pkg::OP_NONE;
    if (idle && req.load) begin
      case (req.size)
        lsu_pkg::SIZE_BYTE: cmd = lsu_pkg::OP_LD_B;
        lsu_pkg::SIZE_HALF: cmd = lsu_pkg::OP_LD_H;
        lsu_pkg::SIZE_WORD: cmd = lsu_pkg::OP_LD_W;
        default:            cmd = lsu_pkg::OP_NONE;  // size 3 is not an access
      endcase
    end else if (idle && req.store) begin
      case (req.size)
        lsu_pkg::SIZE_BYTE: cmd = lsu_pkg::OP_ST_B;
        lsu_pkg::SIZE_HALF: cmd = lsu_pkg::OP_ST_H;
        lsu_pkg::SIZE_WORD: cmd = lsu_pkg::OP_ST_W;
        default:            cmd = lsu_pkg::OP_NONE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      hold_q <= '0;
    end else if (cmd != lsu_pkg::OP_NONE) begin  // accept edge
      hold_q.is_signed <= req.is_signed;
      hold_q.byte_lo   <= req.addr[0];
      hold_q.half_addr <= lsu_pkg::hidx_t'(req.addr[ADDR_W-1:1]);
      hold_q.wdata     <= req.wdata;
    end
  end

  assign hold = hold_q;  // steady until the next accept

endmodule

//--- rtl/lsu_fsm.sv
// execute stage sequencer of the load/store unit
// one or two memory accesses per request, control struct per state

`timescale 1ns/1ps

module lsu_fsm (
  input  logic               clk,
  input  logic               reset,
  input  lsu_pkg::op_e       cmd,
  output lsu_pkg::lsu_ctrl_t ctrl,
  output logic               idle,
  output logic               busy
);

  lsu_pkg::state_e state_q;
  lsu_pkg::state_e state_d;

  always_ff @(posedge clk) begin
    if (!reset) begin
      state_q <= lsu_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // next state
  always_comb begin
    state_d = lsu_pkg::IDLE;  // single-access states fall back here
    case (state_q)
      lsu_pkg::IDLE: begin
        case (cmd)
          lsu_pkg::OP_LD_B: state_d = lsu_pkg::LD_BYTE;
          lsu_pkg::OP_LD_H: state_d = lsu_pkg::LD_HALF;
          lsu_pkg::OP_LD_W: state_d = lsu_pkg::LD_WORD_A;
          lsu_pkg::OP_ST_B: state_d = lsu_pkg::ST_BYTE_A;
          lsu_pkg::OP_ST_H: state_d = lsu_pkg::ST_HALF;
          lsu_pkg::OP_ST_W: state_d = lsu_pkg::ST_WORD_A;
          default:          state_d = lsu_pkg::IDLE;
        endcase
      end
      lsu_pkg::LD_WORD_A: state_d = lsu_pkg::LD_WORD_B;
      lsu_pkg::ST_BYTE_A: state_d = lsu_pkg::ST_BYTE_B;
      lsu_pkg::ST_WORD_A: state_d = lsu_pkg::ST_WORD_B;
      default:            state_d = lsu_pkg::IDLE;
    endcase
  end

  // control per state
  always_comb begin
    ctrl.mem_we       = 1'b0;
    ctrl.addr_next    = 1'b0;
    ctrl.wsel         = lsu_pkg::WSEL_LOW;
    ctrl.capture_old  = 1'b0;
    ctrl.capture_hi   = 1'b0;
    ctrl.ld_kind      = lsu_pkg::OP_NONE;
    ctrl.output_valid = 1'b0;
    ctrl.write_done   = 1'b0;
    case (state_q)
      lsu_pkg::LD_HALF: begin
        ctrl.ld_kind      = lsu_pkg::OP_LD_H;
        ctrl.output_valid = 1'b1;
      end
      lsu_pkg::LD_BYTE: begin
        ctrl.ld_kind      = lsu_pkg::OP_LD_B;
        ctrl.output_valid = 1'b1;
      end
      lsu_pkg::LD_WORD_A: begin
        ctrl.ld_kind    = lsu_pkg::OP_LD_W;
        ctrl.capture_hi = 1'b1;  // high half at base index
      end
      lsu_pkg::LD_WORD_B: begin
        ctrl.ld_kind      = lsu_pkg::OP_LD_W;
        ctrl.addr_next    = 1'b1;
        ctrl.output_valid = 1'b1;
      end
      lsu_pkg::ST_HALF: begin
        ctrl.mem_we     = 1'b1;
        ctrl.wsel       = lsu_pkg::WSEL_LOW;
        ctrl.write_done = 1'b1;
      end
      lsu_pkg::ST_BYTE_A: begin
        ctrl.capture_old = 1'b1;  // read before merge
      end
      lsu_pkg::ST_BYTE_B: begin
        ctrl.mem_we     = 1'b1;
        ctrl.wsel       = lsu_pkg::WSEL_MERGE;
        ctrl.write_done = 1'b1;
      end
      lsu_pkg::ST_WORD_A: begin
        ctrl.mem_we = 1'b1;
        ctrl.wsel   = lsu_pkg::WSEL_HIGH;
      end
      lsu_pkg::ST_WORD_B: begin
        ctrl.mem_we     = 1'b1;
        ctrl.addr_next  = 1'b1;
        ctrl.wsel       = lsu_pkg::WSEL_LOW;
        ctrl.write_done = 1'b1;
      end
      default: ;
    endcase
  end

  assign idle = (state_q == lsu_pkg::IDLE);
  assign busy = !idle;

endmodule

//--- rtl/lsu_pkg.sv
// shared types of the load/store unit
// widths, access size, operation, FSM state and write-data select enums
// request, held request and control structs

package lsu_pkg;

  localparam int ADDR_BITS = 16;  // default byte address width

  typedef logic [ADDR_BITS-1:0] addr_t;  // byte address
  typedef logic [ADDR_BITS-2:0] hidx_t;  // halfword index
  typedef logic [15:0]          half_t;  // one memory halfword
  typedef logic [31:0]          word_t;  // load result and store data

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } size_e;

  typedef enum logic [2:0] {
    OP_NONE = 3'd0,
    OP_LD_B = 3'd1,
    OP_LD_H = 3'd2,
    OP_LD_W = 3'd3,
    OP_ST_B = 3'd4,
    OP_ST_H = 3'd5,
    OP_ST_W = 3'd6
  } op_e;

  // store states carry the top bit
  typedef enum logic [3:0] {
    IDLE      = 4'b0000,
    LD_HALF   = 4'b0001,
    LD_BYTE   = 4'b0010,
    LD_WORD_A = 4'b0011,
    LD_WORD_B = 4'b0100,
    ST_HALF   = 4'b1111,
    ST_BYTE_A = 4'b1011,
    ST_BYTE_B = 4'b1010,
    ST_WORD_A = 4'b1101,
    ST_WORD_B = 4'b1100
  } state_e;

  typedef enum logic [1:0] {
    WSEL_HIGH  = 2'd0,  // wdata[31:16]
    WSEL_LOW   = 2'd1,  // wdata[15:0]
    WSEL_MERGE = 2'd2   // new byte plus old byte
  } wsel_e;

  typedef struct packed {
    logic  load;
    logic  store;
    size_e size;
    logic  is_signed;
    addr_t addr;
    word_t wdata;
  } lsu_req_t;

  typedef struct packed {
    logic  is_signed;
    logic  byte_lo;    // address bit 0 selects the low byte
    hidx_t half_addr;
    word_t wdata;
  } lsu_hold_t;

  typedef struct packed {
    logic  mem_we;
    logic  addr_next;     // second halfword of a word
    wsel_e wsel;
    logic  capture_old;
    logic  capture_hi;
    op_e   ld_kind;
    logic  output_valid;
    logic  write_done;
  } lsu_ctrl_t;

endpackage

//--- rtl/lsu_result.sv
// result stage of the load/store unit
// first half capture of a word load, load data extension

`timescale 1ns/1ps

module lsu_result (
  input  logic               clk,
  input  logic               reset,
  input  lsu_pkg::lsu_ctrl_t ctrl,
  input  lsu_pkg::lsu_hold_t hold,
  input  lsu_pkg::half_t     ram_rdata,
  output lsu_pkg::word_t     rdata
);

  lsu_pkg::half_t hi_q;
  logic [7:0]     sel_byte;
  logic           ext_h;
  logic           ext_b;

  always_ff @(posedge clk) begin
    if (!reset) begin
      hi_q <= '0;
    end else if (ctrl.capture_hi) begin
      hi_q <= ram_rdata;  // high half comes first
    end
  end

  assign sel_byte = hold.byte_lo ? ram_rdata[7:0] : ram_rdata[15:8];
  assign ext_h    = hold.is_signed & ram_rdata[15];
  assign ext_b    = hold.is_signed & sel_byte[7];

  always_comb begin
    case (ctrl.ld_kind)
      lsu_pkg::OP_LD_W: begin
        rdata = {hi_q, ram_rdata};
      end
      lsu_pkg::OP_LD_H: begin
        rdata = {{16{ext_h}}, ram_rdata};
      end
      lsu_pkg::OP_LD_B: begin
        rdata = {{24{ext_b}}, sel_byte};
      end
      default: begin
        rdata = '0;  // no load in flight
      end
    endcase
  end

endmodule

//--- rtl/lsu_top.sv
// load/store unit top level
// decode, sequencer, datapath, result stage and halfword RAM

`timescale 1ns/1ps

module lsu_top #(
  parameter int ADDR_W = 16
) (
  input  logic              clk,
  input  logic              reset,
  input  lsu_pkg::lsu_req_t req,
  output lsu_pkg::word_t    rdata,
  output logic              output_valid,
  output logic              write_done,
  output logic              busy
);

  lsu_pkg::op_e       cmd;
  lsu_pkg::lsu_hold_t hold;
  lsu_pkg::lsu_ctrl_t ctrl;
  logic               idle;
  logic [ADDR_W-2:0]  ram_addr;
  logic               ram_we;
  lsu_pkg::half_t     ram_wdata;
  lsu_pkg::half_t     ram_rdata;

  lsu_decode #(.ADDR_W(ADDR_W)) decode0 (
    .clk   (clk),
    .reset (reset),
    .req   (req),
    .idle  (idle),
    .cmd   (cmd),
    .hold  (hold)
  );

  lsu_fsm fsm0 (
    .clk   (clk),
    .reset (reset),
    .cmd   (cmd),
    .ctrl  (ctrl),
    .idle  (idle),
    .busy  (busy)
  );

  lsu_datapath #(.ADDR_W(ADDR_W)) datapath0 (
    .clk       (clk),
    .reset     (reset),
    .ctrl      (ctrl),
    .hold      (hold),
    .ram_rdata (ram_rdata),
    .ram_addr  (ram_addr),
    .ram_we    (ram_we),
    .ram_wdata (ram_wdata)
  );

  lsu_result result0 (
    .clk       (clk),
    .reset     (reset),
    .ctrl      (ctrl),
    .hold      (hold),
    .ram_rdata (ram_rdata),
    .rdata     (rdata)
  );

  halfword_ram #(.ADDR_W(ADDR_W)) ram0 (
    .clk   (clk),
    .addr  (ram_addr),
    .we    (ram_we),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

  assign output_valid = ctrl.output_valid;
  assign write_done   = ctrl.write_done;

endmodule

//--- src.f
rtl/lsu_pkg.sv
rtl/lsu_decode.sv
rtl/lsu_fsm.sv
rtl/lsu_datapath.sv
rtl/lsu_result.sv
rtl/halfword_ram.sv
rtl/lsu_top.sv
dv/lsu_tb.sv
